// ==== dm_sysbus.f ====
+incdir+hdl
hdl/dm_sb_pkg.sv
hdl/sb_reg_file.sv
hdl/sb_access_ctrl.sv
hdl/sb_axi_master.sv
hdl/dm_sysbus.sv
tests/sb_checker.sv
tests/tb_dm_sysbus.sv

// ==== run.sh ====
#!/bin/sh
# build and run with Verilator, result decided from sim.log
( verilator --binary --timing --assert -f dm_sysbus.f --top-module tb_dm_sysbus \
    -o tb_sim && ./obj_dir/tb_sim ) > sim.log 2>&1 || echo ">>> FAIL" >> sim.log
cat sim.log
grep -q ">>> FAIL" sim.log && exit 1 || exit 0

// ==== tests/tb_dm_sysbus.sv ====
`timescale 1ns/1ps
`include "dm_sb_macros.svh"

module tb_dm_sysbus;

    localparam int NROWS      = 39;
    localparam int MAX_CYCLES = NROWS * 40;

    localparam logic [2:0] OP_NOP     = 3'd0;
    localparam logic [2:0] OP_WCS     = 3'd1;
    localparam logic [2:0] OP_WADR    = 3'd2;
    localparam logic [2:0] OP_WDAT    = 3'd3;
    localparam logic [2:0] OP_RDAT    = 3'd4;
    localparam logic [2:0] OP_WADR_NW = 3'd5;  // no wait for sbbusy
    localparam logic [2:0] OP_DMOFF   = 3'd6;

    localparam logic [2:0] SEL_NONE = 3'd0;
    localparam logic [2:0] SEL_DATA = 3'd1;
    localparam logic [2:0] SEL_ADDR = 3'd2;
    localparam logic [2:0] SEL_ERR  = 3'd3;
    localparam logic [2:0] SEL_BERR = 3'd4;
    localparam logic [2:0] SEL_CS   = 3'd5;

    logic dm_clk = 1'b0;
    logic dm_rst_n, dmactive, dm_reg_wen, dm_reg_ren;
    logic [`DM_SB_ABITS-1:0] dm_reg_addr;
    logic [31:0] dm_reg_data, dm_sbcs, dm_sbaddress0, dm_sbdata0;
    logic slv_awvalid, slv_awready, slv_wvalid, slv_wready, slv_bvalid, slv_bready;
    logic slv_arvalid, slv_arready, slv_rvalid, slv_rready;
    logic [31:0] slv_awaddr, slv_wdata, slv_araddr, slv_rdata;
    logic [2:0] slv_awsize, slv_arsize;
    logic [3:0] slv_wstrb;
    logic [1:0] slv_bresp, slv_rresp;
    logic chk_en;
    logic [2:0] chk_sel;
    logic [31:0] chk_exp;
    logic [2:0] exp_size;
    int err_cnt;
    int cycles = 0;
    int seed = 32'hb46;
    int nrow = 0;

    logic [2:0]  op_tab  [NROWS];
    logic [31:0] dat_tab [NROWS];
    logic [2:0]  sel_tab [NROWS];
    logic [31:0] exp_tab [NROWS];

    logic [31:0] mem [0:63];
    logic [1:0] aw_dly, w_dly, ar_dly, b_dly, r_dly;
    logic have_aw, have_w, r_pend, aw_hs, w_hs, ar_hs, b_hs, r_hs;
    logic [31:0] wr_addr, wr_data, rd_addr;
    logic [3:0] wr_strb;

    always #4 dm_clk = ~dm_clk;

    dm_sysbus i_dm_sysbus (.*);

    sb_checker i_checker (.*);

    always @(posedge dm_clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout after %0d cycles, sbbusy never dropped", cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    // ready after 0 to 3 idle cycles of a pending valid
    task automatic step_ready(inout logic rdy, inout logic [1:0] dly, input logic hs,
                              input logic vld);
        if (hs) begin
            rdy = 1'b0;
            dly = 2'($random(seed));
        end else if (vld && !rdy) begin
            if (dly == 2'd0) rdy = 1'b1;
            else dly = dly - 2'd1;
        end
    endtask

    always @(posedge dm_clk) begin
        aw_hs = slv_awvalid && slv_awready;
        w_hs  = slv_wvalid && slv_wready;
        ar_hs = slv_arvalid && slv_arready;
        b_hs  = slv_bvalid && slv_bready;
        r_hs  = slv_rvalid && slv_rready;
        if (aw_hs) wr_addr = slv_awaddr;
        if (w_hs) begin
            wr_data = slv_wdata;
            wr_strb = slv_wstrb;
        end
        if (ar_hs) rd_addr = slv_araddr;
        #1;
        have_aw = have_aw | aw_hs;
        have_w  = have_w | w_hs;
        r_pend  = r_pend | ar_hs;
        step_ready(slv_awready, aw_dly, aw_hs, slv_awvalid);
        step_ready(slv_wready, w_dly, w_hs, slv_wvalid);
        step_ready(slv_arready, ar_dly, ar_hs, slv_arvalid);
        if (b_hs) begin
            slv_bvalid = 1'b0;
            b_dly = 2'($random(seed));
        end else if (have_aw && have_w && !slv_bvalid) begin
            if (b_dly != 2'd0) begin
                b_dly = b_dly - 2'd1;
            end else begin
                for (int k = 0; k < 4; k++) begin
                    if (wr_strb[k] && wr_addr < 32'h1000) begin
                        mem[wr_addr[7:2]][8*k +: 8] = wr_data[8*k +: 8];
                    end
                end
                slv_bresp  = (wr_addr < 32'h1000) ? 2'b00 : 2'b10;  // slverr above 0x1000
                slv_bvalid = 1'b1;
                have_aw    = 1'b0;
                have_w     = 1'b0;
            end
        end
        if (r_hs) begin
            slv_rvalid = 1'b0;
            r_dly = 2'($random(seed));
        end else if (r_pend && !slv_rvalid) begin
            if (r_dly != 2'd0) begin
                r_dly = r_dly - 2'd1;
            end else begin
                slv_rdata  = mem[rd_addr[7:2]];
                slv_rresp  = (rd_addr < 32'h1000) ? 2'b00 : 2'b10;
                slv_rvalid = 1'b1;
                r_pend     = 1'b0;
            end
        end
    end

    task automatic add_row(input logic [2:0] op, input logic [31:0] dat, input logic [2:0] sel,
                           input logic [31:0] exp);
        op_tab[nrow]  = op;
        dat_tab[nrow] = dat;
        sel_tab[nrow] = sel;
        exp_tab[nrow] = exp;
        nrow++;
    endtask

    task automatic reg_access(input logic wen, input logic ren, input logic [6:0] addr,
                              input logic [31:0] data);
        dm_reg_wen  = wen;
        dm_reg_ren  = ren;
        dm_reg_addr = addr;
        dm_reg_data = data;
        @(posedge dm_clk);
        #1;
        dm_reg_wen = 1'b0;
        dm_reg_ren = 1'b0;
    endtask

    task automatic apply_row(input logic [2:0] op, input logic [31:0] data);
        case (op)
            OP_WCS: begin
                exp_size = data[19:17];
                reg_access(1'b1, 1'b0, `DM_SB_ADDR_SBCS, data);
            end
            OP_WADR, OP_WADR_NW: reg_access(1'b1, 1'b0, `DM_SB_ADDR_SBADDR0, data);
            OP_WDAT:             reg_access(1'b1, 1'b0, `DM_SB_ADDR_SBDATA0, data);
            OP_RDAT:             reg_access(1'b0, 1'b1, `DM_SB_ADDR_SBDATA0, 32'h0);
            OP_DMOFF: begin
                exp_size = 3'd2;  // sbaccess back to word
                dmactive = 1'b0;
                @(posedge dm_clk);
                #1;
                dmactive = 1'b1;
            end
            default: ;
        endcase
        if (op != OP_WADR_NW) begin
            while (dm_sbcs[21]) begin
                @(posedge dm_clk);
                #1;
            end
        end
    endtask

    initial begin
        {dm_rst_n, dm_reg_wen, dm_reg_ren, chk_en} = '0;
        {slv_awready, slv_wready, slv_bvalid, slv_arready, slv_rvalid} = '0;
        {have_aw, have_w, r_pend, aw_dly, w_dly, ar_dly, b_dly, r_dly} = '0;
        dmactive    = 1'b1;
        dm_reg_addr = '0;
        dm_reg_data = '0;
        slv_bresp   = 2'b00;
        slv_rresp   = 2'b00;
        slv_rdata   = '0;
        chk_sel     = SEL_NONE;
        chk_exp     = '0;
        exp_size    = 3'd2;
        for (int k = 0; k < 64; k++) mem[k] = 32'h01010101 * 32'(k) + 32'h10203040;
        // word write, readback through readonaddr
        add_row(OP_WCS, 32'h140000, SEL_NONE, 0);
        add_row(OP_WADR, 32'h10, SEL_NONE, 0);
        add_row(OP_WDAT, 32'hcafef00d, SEL_NONE, 0);
        add_row(OP_WADR, 32'h10, SEL_DATA, 32'hcafef00d);
        // byte and half lanes
        add_row(OP_WCS, 32'h0, SEL_NONE, 0);
        add_row(OP_WADR, 32'h21, SEL_NONE, 0);
        add_row(OP_WDAT, 32'hab, SEL_NONE, 0);
        add_row(OP_WADR, 32'h23, SEL_NONE, 0);
        add_row(OP_WDAT, 32'hcd, SEL_NONE, 0);
        add_row(OP_WCS, 32'h20000, SEL_NONE, 0);
        add_row(OP_WADR, 32'h20, SEL_NONE, 0);
        add_row(OP_WDAT, 32'h5566, SEL_NONE, 0);
        add_row(OP_WADR, 32'h26, SEL_NONE, 0);
        add_row(OP_WDAT, 32'h7788, SEL_NONE, 0);
        // autoincrement and readondata
        add_row(OP_WCS, 32'h158000, SEL_NONE, 0);
        add_row(OP_WADR, 32'h20, SEL_DATA, 32'hcd285566);
        add_row(OP_RDAT, 32'h0, SEL_DATA, 32'h77883949);
        add_row(OP_WCS, 32'h110000, SEL_ADDR, 32'h28);
        add_row(OP_WADR, 32'h24, SEL_DATA, 32'h49);
        add_row(OP_WCS, 32'h130000, SEL_ADDR, 32'h25);
        add_row(OP_WADR, 32'h26, SEL_DATA, 32'h7788);
        add_row(OP_WCS, 32'h140000, SEL_ADDR, 32'h28);
        // sbbusyerror
        add_row(OP_WADR_NW, 32'h30, SEL_NONE, 0);
        add_row(OP_WADR, 32'h34, SEL_BERR, 32'h1);
        add_row(OP_WADR, 32'h10, SEL_DATA, 32'h1c2c3c4c);
        add_row(OP_WCS, 32'h540000, SEL_BERR, 32'h0);
        add_row(OP_WADR, 32'h10, SEL_DATA, 32'hcafef00d);
        // sberror codes
        add_row(OP_WCS, 32'h160000, SEL_NONE, 0);
        add_row(OP_WADR, 32'h10, SEL_ERR, 32'h4);
        add_row(OP_WCS, 32'h147000, SEL_ERR, 32'h0);
        add_row(OP_WCS, 32'h120000, SEL_NONE, 0);
        add_row(OP_WADR, 32'h11, SEL_ERR, 32'h3);
        add_row(OP_WCS, 32'h157000, SEL_ERR, 32'h0);
        add_row(OP_WADR, 32'h1000, SEL_ERR, 32'h2);
        add_row(OP_NOP, 32'h0, SEL_ADDR, 32'h1000);
        add_row(OP_WCS, 32'h157000, SEL_ERR, 32'h0);
        // dmactive low
        add_row(OP_DMOFF, 32'h0, SEL_CS, 32'h20040407);
        add_row(OP_NOP, 32'h0, SEL_ADDR, 32'h0);
        add_row(OP_NOP, 32'h0, SEL_DATA, 32'h0);
        repeat (2) @(posedge dm_clk);
        #1;
        dm_rst_n = 1'b1;
        for (int i = 0; i < NROWS; i++) begin
            apply_row(op_tab[i], dat_tab[i]);
            if (sel_tab[i] != SEL_NONE) begin
                chk_sel = sel_tab[i];
                chk_exp = exp_tab[i];
                chk_en  = 1'b1;
                @(posedge dm_clk);
                #1;
                chk_en = 1'b0;
            end
        end
        @(posedge dm_clk);
        #1;
        i_checker.report_counts();
        if (err_cnt == 0) $display(">>> PASS");
        else $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== tests/sb_checker.sv ====
`timescale 1ns/1ps

module sb_checker (
    input  logic        dm_clk,
    input  logic        dm_rst_n,
    input  logic [31:0] dm_sbcs,
    input  logic [31:0] dm_sbaddress0,
    input  logic [31:0] dm_sbdata0,
    input  logic        slv_awvalid,
    input  logic        slv_awready,
    input  logic        slv_wvalid,
    input  logic        slv_wready,
    input  logic [3:0]  slv_wstrb,
    input  logic [31:0] slv_awaddr,
    input  logic [2:0]  slv_awsize,
    input  logic        slv_arvalid,
    input  logic        slv_arready,
    input  logic [2:0]  slv_arsize,
    input  logic [2:0]  exp_size,
    input  logic        chk_en,
    input  logic [2:0]  chk_sel,
    input  logic [31:0] chk_exp,
    output int          err_cnt
);

    localparam logic [2:0] SEL_DATA = 3'd1;
    localparam logic [2:0] SEL_ADDR = 3'd2;
    localparam logic [2:0] SEL_ERR  = 3'd3;
    localparam logic [2:0] SEL_BERR = 3'd4;
    localparam logic [2:0] SEL_CS   = 3'd5;

    int val_errs = 0;
    int strb_errs = 0;
    int size_errs = 0;

    // lanes covered by one beat of the given size
    function automatic logic [3:0] lane_mask(input logic [2:0] size, input logic [1:0] lo);
        logic [3:0] base;
        base = (size == 3'd0) ? 4'b0001 : (size == 3'd1) ? 4'b0011 : 4'b1111;
        return base << lo;
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            val_errs++;
        end
    endtask

    always @(posedge dm_clk) begin
        if (dm_rst_n && chk_en) begin
            case (chk_sel)
                SEL_DATA: compare("sbdata0", dm_sbdata0, chk_exp);
                SEL_ADDR: compare("sbaddress0", dm_sbaddress0, chk_exp);
                SEL_ERR:  compare("sberror", 32'(dm_sbcs[14:12]), chk_exp);
                SEL_BERR: compare("sbbusyerror", 32'(dm_sbcs[22]), chk_exp);
                SEL_CS:   compare("sbcs", dm_sbcs, chk_exp);
                default:  ;
            endcase
        end
        if (dm_rst_n && slv_wvalid && slv_wready &&
            slv_wstrb !== lane_mask(exp_size, slv_awaddr[1:0])) begin
            $display("Mismatch wstrb: got %h expected %h", slv_wstrb,
                     lane_mask(exp_size, slv_awaddr[1:0]));
            strb_errs++;
        end
        if (dm_rst_n && slv_awvalid && slv_awready && slv_awsize !== exp_size) begin
            $display("Mismatch awsize: got %h expected %h", slv_awsize, exp_size);
            size_errs++;
        end
        if (dm_rst_n && slv_arvalid && slv_arready && slv_arsize !== exp_size) begin
            $display("Mismatch arsize: got %h expected %h", slv_arsize, exp_size);
            size_errs++;
        end
    end

    assign err_cnt = val_errs + strb_errs + size_errs;

    task automatic report_counts();
        $display("errors: %0d register, %0d strobe, %0d size, %0d total",
                 val_errs, strb_errs, size_errs, err_cnt);
    endtask

endmodule

// ==== hdl/dm_sysbus.sv ====
`timescale 1ns/1ps
`include "dm_sb_macros.svh"

module dm_sysbus (
    input  logic                          dm_clk,
    input  logic                          dm_rst_n,
    input  logic                          dmactive,
    input  logic                          dm_reg_wen,
    input  logic                          dm_reg_ren,
    input  logic [`DM_SB_ABITS-1:0]       dm_reg_addr,
    input  logic [`DM_SB_DATA_W-1:0]      dm_reg_data,
    output logic [31:0]                   dm_sbcs,
    output logic [`DM_SB_ADDR_W-1:0]      dm_sbaddress0,
    output logic [`DM_SB_DATA_W-1:0]      dm_sbdata0,
    output logic                          slv_awvalid,
    input  logic                          slv_awready,
    output logic [`DM_SB_ADDR_W-1:0]      slv_awaddr,
    output logic [2:0]                    slv_awsize,
    output logic                          slv_wvalid,
    input  logic                          slv_wready,
    output logic [`DM_SB_DATA_W-1:0]      slv_wdata,
    output logic [`DM_SB_STRB_W-1:0]      slv_wstrb,
    input  logic                          slv_bvalid,
    output logic                          slv_bready,
    input  logic [1:0]                    slv_bresp,
    output logic                          slv_arvalid,
    input  logic                          slv_arready,
    output logic [`DM_SB_ADDR_W-1:0]      slv_araddr,
    output logic [2:0]                    slv_arsize,
    input  logic                          slv_rvalid,
    output logic                          slv_rready,
    input  logic [1:0]                    slv_rresp,
    input  logic [`DM_SB_DATA_W-1:0]      slv_rdata
);

    import dm_sb_pkg::*;

    sb_cs_fields_t             cs_cfg;
    sb_err_e                   sberror;
    logic                      sbbusyerror;
    logic                      busy;
    logic                      req_rd_addr;
    logic                      req_wr_data;
    logic                      req_rd_data;
    logic [1:0]                req_addr_lo;
    logic [2:0]                err_clear;
    logic                      start_rd;
    logic                      start_wr;
    logic                      rsp_valid;
    logic                      rsp_err;
    logic                      rsp_is_read;
    logic [`DM_SB_DATA_W-1:0]  load_data;

    sb_reg_file i_reg_file (
        .dm_clk      (dm_clk),
        .dm_rst_n    (dm_rst_n),
        .dmactive    (dmactive),
        .dm_reg_wen  (dm_reg_wen),
        .dm_reg_ren  (dm_reg_ren),
        .dm_reg_addr (dm_reg_addr),
        .dm_reg_data (dm_reg_data),
        .busy        (busy),
        .rsp_valid   (rsp_valid),
        .rsp_err     (rsp_err),
        .rsp_is_read (rsp_is_read),
        .load_data   (load_data),
        .cs_cfg      (cs_cfg),
        .sbbusyerror (sbbusyerror),
        .sbaddress0  (dm_sbaddress0),
        .sbdata0     (dm_sbdata0),
        .req_rd_addr (req_rd_addr),
        .req_wr_data (req_wr_data),
        .req_rd_data (req_rd_data),
        .req_addr_lo (req_addr_lo),
        .err_clear   (err_clear)
    );

    sb_access_ctrl i_access_ctrl (
        .dm_clk      (dm_clk),
        .dm_rst_n    (dm_rst_n),
        .dmactive    (dmactive),
        .req_rd_addr (req_rd_addr),
        .req_wr_data (req_wr_data),
        .req_rd_data (req_rd_data),
        .req_addr_lo (req_addr_lo),
        .sbaccess    (cs_cfg.access),
        .sbbusyerror (sbbusyerror),
        .err_clear   (err_clear),
        .rsp_valid   (rsp_valid),
        .rsp_err     (rsp_err),
        .start_rd    (start_rd),
        .start_wr    (start_wr),
        .busy        (busy),
        .sberror     (sberror)
    );

    sb_axi_master i_axi_master (
        .dm_clk      (dm_clk),
        .dm_rst_n    (dm_rst_n),
        .start_rd    (start_rd),
        .start_wr    (start_wr),
        .addr        (dm_sbaddress0),
        .size        (cs_cfg.access),
        .store_data  (dm_sbdata0),
        .awready     (slv_awready),
        .wready      (slv_wready),
        .bvalid      (slv_bvalid),
        .bresp       (slv_bresp),
        .arready     (slv_arready),
        .rvalid      (slv_rvalid),
        .rresp       (slv_rresp),
        .rdata       (slv_rdata),
        .awvalid     (slv_awvalid),
        .awaddr      (slv_awaddr),
        .awsize      (slv_awsize),
        .wvalid      (slv_wvalid),
        .wdata       (slv_wdata),
        .wstrb       (slv_wstrb),
        .bready      (slv_bready),
        .arvalid     (slv_arvalid),
        .araddr      (slv_araddr),
        .arsize      (slv_arsize),
        .rready      (slv_rready),
        .rsp_valid   (rsp_valid),
        .rsp_err     (rsp_err),
        .rsp_is_read (rsp_is_read),
        .load_data   (load_data)
    );

    // 8, 16 and 32 bit accesses only
    assign dm_sbcs = {3'(`DM_SB_VERSION), 6'h00, sbbusyerror, busy,
                      cs_cfg.readonaddr, cs_cfg.access, cs_cfg.autoincrement,
                      cs_cfg.readondata, sberror, 7'(`DM_SB_ADDR_W),
                      1'b0, 1'b0, 1'b1, 1'b1, 1'b1};

endmodule

// ==== hdl/sb_axi_master.sv ====
`timescale 1ns/1ps
`include "dm_sb_macros.svh"

module sb_axi_master (
    input  logic                          dm_clk,
    input  logic                          dm_rst_n,
    input  logic                          start_rd,
    input  logic                          start_wr,
    input  logic [`DM_SB_ADDR_W-1:0]      addr,
    input  dm_sb_pkg::sb_size_e           size,
    input  logic [`DM_SB_DATA_W-1:0]      store_data,
    input  logic                          awready,
    input  logic                          wready,
    input  logic                          bvalid,
    input  logic [1:0]                    bresp,
    input  logic                          arready,
    input  logic                          rvalid,
    input  logic [1:0]                    rresp,
    input  logic [`DM_SB_DATA_W-1:0]      rdata,
    output logic                          awvalid,
    output logic [`DM_SB_ADDR_W-1:0]      awaddr,
    output logic [2:0]                    awsize,
    output logic                          wvalid,
    output logic [`DM_SB_DATA_W-1:0]      wdata,
    output logic [`DM_SB_STRB_W-1:0]      wstrb,
    output logic                          bready,
    output logic                          arvalid,
    output logic [`DM_SB_ADDR_W-1:0]      araddr,
    output logic [2:0]                    arsize,
    output logic                          rready,
    output logic                          rsp_valid,
    output logic                          rsp_err,
    output logic                          rsp_is_read,
    output logic [`DM_SB_DATA_W-1:0]      load_data
);

    import dm_sb_pkg::*;

    logic                      wr_busy;
    logic                      rd_busy;
    logic                      b_fire;
    logic                      r_fire;
    logic [`DM_SB_STRB_W-1:0]  strb_base;
    logic [`DM_SB_DATA_W-1:0]  rd_shift;

    always_ff @(posedge dm_clk or negedge dm_rst_n) begin
        if (!dm_rst_n) begin
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            arvalid <= 1'b0;
            wr_busy <= 1'b0;
            rd_busy <= 1'b0;
        end else begin
            // aw and w retire independently
            if (start_wr) awvalid <= 1'b1;
            else if (awready) awvalid <= 1'b0;
            if (start_wr) wvalid <= 1'b1;
            else if (wready) wvalid <= 1'b0;
            if (start_rd) arvalid <= 1'b1;
            else if (arready) arvalid <= 1'b0;
            if (start_wr) wr_busy <= 1'b1;
            else if (b_fire) wr_busy <= 1'b0;
            if (start_rd) rd_busy <= 1'b1;
            else if (r_fire) rd_busy <= 1'b0;
        end
    end

    assign bready = 1'b1;
    assign rready = 1'b1;

    // b only counts once both aw and w went out
    assign b_fire = wr_busy & ~awvalid & ~wvalid & bvalid & bready;
    assign r_fire = rd_busy & ~arvalid & rvalid & rready;

    assign rsp_valid   = b_fire | r_fire;
    assign rsp_is_read = r_fire;
    assign rsp_err     = b_fire ? (bresp != `DM_SB_RESP_OKAY) : (rresp != `DM_SB_RESP_OKAY);

    assign awaddr = addr;
    assign araddr = addr;
    assign awsize = size;
    assign arsize = size;

    always_comb begin
        case (size)
            SB_SIZE_BYTE: strb_base = 4'b0001;
            SB_SIZE_HALF: strb_base = 4'b0011;
            default:      strb_base = 4'b1111;
        endcase
    end

    assign wstrb = strb_base << addr[1:0];
    assign wdata = store_data << {addr[1:0], 3'b000};  // onto byte lane

    assign rd_shift = rdata >> {addr[1:0], 3'b000};

    always_comb begin
        case (size)
            SB_SIZE_BYTE: load_data = {24'h0, rd_shift[7:0]};
            SB_SIZE_HALF: load_data = {16'h0, rd_shift[15:0]};
            default:      load_data = rd_shift;
        endcase
    end

    // payload comes from the reg file and must hold with the valid
    a_aw_hold: assert property (@(posedge dm_clk) disable iff (!dm_rst_n)
        awvalid && !awready |=> awvalid && $stable(awaddr));
    a_w_hold: assert property (@(posedge dm_clk) disable iff (!dm_rst_n)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb));
    a_ar_hold: assert property (@(posedge dm_clk) disable iff (!dm_rst_n)
        arvalid && !arready |=> arvalid && $stable(araddr));

endmodule

// ==== hdl/sb_access_ctrl.sv ====
`timescale 1ns/1ps

module sb_access_ctrl (
    input  logic                  dm_clk,
    input  logic                  dm_rst_n,
    input  logic                  dmactive,
    input  logic                  req_rd_addr,
    input  logic                  req_wr_data,
    input  logic                  req_rd_data,
    input  logic [1:0]            req_addr_lo,
    input  dm_sb_pkg::sb_size_e   sbaccess,
    input  logic                  sbbusyerror,
    input  logic [2:0]            err_clear,
    input  logic                  rsp_valid,
    input  logic                  rsp_err,
    output logic                  start_rd,
    output logic                  start_wr,
    output logic                  busy,
    output dm_sb_pkg::sb_err_e    sberror
);

    import dm_sb_pkg::*;

    logic any_req;
    logic may_go;
    logic size_ok;
    logic misalign;
    logic start_ok;

    assign any_req = req_rd_addr | req_wr_data | req_rd_data;

    // a new access only with a clean error state
    assign may_go = any_req & (sberror == SB_ERR_NONE) & ~sbbusyerror;

    assign size_ok = (sbaccess == SB_SIZE_BYTE) || (sbaccess == SB_SIZE_HALF) ||
                     (sbaccess == SB_SIZE_WORD);

    always_comb begin
        case (sbaccess)
            SB_SIZE_HALF: misalign = req_addr_lo[0];
            SB_SIZE_WORD: misalign = |req_addr_lo;
            default:      misalign = 1'b0;
        endcase
    end

    assign start_ok = may_go & size_ok & ~misalign;
    assign start_rd = start_ok & (req_rd_addr | req_rd_data);
    assign start_wr = start_ok & req_wr_data;

    always_ff @(posedge dm_clk or negedge dm_rst_n) begin
        if (!dm_rst_n) begin
            busy <= 1'b0;
        end else if (!dmactive) begin
            busy <= 1'b0;
        end else if (start_rd || start_wr) begin
            busy <= 1'b1;
        end else if (rsp_valid) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge dm_clk or negedge dm_rst_n) begin
        if (!dm_rst_n) begin
            sberror <= SB_ERR_NONE;
        end else if (!dmactive) begin
            sberror <= SB_ERR_NONE;
        end else if (|err_clear) begin
            sberror <= sb_err_e'(sberror & ~err_clear);  // w1c per bit
        end else if (may_go && !size_ok) begin
            sberror <= SB_ERR_SIZE;  // wins over alignment
        end else if (may_go && misalign) begin
            sberror <= SB_ERR_ALIGN;
        end else if (rsp_valid && rsp_err) begin
            sberror <= SB_ERR_BUS;
        end
    end

    // reg file must hold requests back while an access is out
    a_no_start_busy: assert property (@(posedge dm_clk) disable iff (!dm_rst_n)
        (start_rd || start_wr) |-> !busy);

endmodule

// ==== hdl/sb_reg_file.sv ====
`timescale 1ns/1ps
`include "dm_sb_macros.svh"

module sb_reg_file (
    input  logic                          dm_clk,
    input  logic                          dm_rst_n,
    input  logic                          dmactive,
    input  logic                          dm_reg_wen,
    input  logic                          dm_reg_ren,
    input  logic [`DM_SB_ABITS-1:0]       dm_reg_addr,
    input  dm_sb_pkg::sb_wword_u          dm_reg_data,
    input  logic                          busy,
    input  logic                          rsp_valid,
    input  logic                          rsp_err,
    input  logic                          rsp_is_read,
    input  logic [`DM_SB_DATA_W-1:0]      load_data,
    output dm_sb_pkg::sb_cs_fields_t      cs_cfg,
    output logic                          sbbusyerror,
    output logic [`DM_SB_ADDR_W-1:0]      sbaddress0,
    output logic [`DM_SB_DATA_W-1:0]      sbdata0,
    output logic                          req_rd_addr,
    output logic                          req_wr_data,
    output logic                          req_rd_data,
    output logic [1:0]                    req_addr_lo,
    output logic [2:0]                    err_clear
);

    import dm_sb_pkg::*;

    sb_cs_fields_t             cfg_q;
    logic                      hit_cs;
    logic                      hit_addr;
    logic                      hit_data;
    logic                      cs_wen;
    logic                      addr_wen;
    logic                      data_wen;
    logic                      sb_touch;
    logic [`DM_SB_ADDR_W-1:0]  addr_step;

    assign hit_cs   = (dm_reg_addr == `DM_SB_ADDR_SBCS);
    assign hit_addr = (dm_reg_addr == `DM_SB_ADDR_SBADDR0);
    assign hit_data = (dm_reg_addr == `DM_SB_ADDR_SBDATA0);

    assign cs_wen   = dm_reg_wen & hit_cs & ~busy;
    assign addr_wen = dm_reg_wen & hit_addr & ~busy;
    assign data_wen = dm_reg_wen & hit_data & ~busy;
    assign sb_touch = (dm_reg_wen & hit_addr) | ((dm_reg_wen | dm_reg_ren) & hit_data);

    // request strobes towards the access controller
    assign req_rd_addr = addr_wen & cfg_q.readonaddr;
    assign req_wr_data = data_wen;
    assign req_rd_data = dm_reg_ren & hit_data & ~busy & cfg_q.readondata;
    assign req_addr_lo = addr_wen ? dm_reg_data.raw[1:0] : sbaddress0[1:0];

    assign err_clear = cs_wen ? dm_reg_data.cs.err_clr : 3'b000;
    assign cs_cfg    = cfg_q;
    assign addr_step = `DM_SB_ADDR_W'(1) << cfg_q.access;  // 1, 2 or 4 bytes

    always_ff @(posedge dm_clk or negedge dm_rst_n) begin
        if (!dm_rst_n) begin
            cfg_q        <= '0;
            cfg_q.access <= SB_SIZE_WORD;
        end else if (!dmactive) begin
            cfg_q        <= '0;
            cfg_q.access <= SB_SIZE_WORD;
        end else if (cs_wen) begin
            cfg_q.readonaddr    <= dm_reg_data.cs.readonaddr;
            cfg_q.access        <= dm_reg_data.cs.access;
            cfg_q.autoincrement <= dm_reg_data.cs.autoincrement;
            cfg_q.readondata    <= dm_reg_data.cs.readondata;
        end
    end

    always_ff @(posedge dm_clk or negedge dm_rst_n) begin
        if (!dm_rst_n) begin
            sbbusyerror <= 1'b0;
        end else if (!dmactive) begin
            sbbusyerror <= 1'b0;
        end else if (cs_wen && dm_reg_data.cs.busyerror_clr) begin
            sbbusyerror <= 1'b0;
        end else if (busy && sb_touch) begin
            sbbusyerror <= 1'b1;  // poked while busy
        end
    end

    always_ff @(posedge dm_clk or negedge dm_rst_n) begin
        if (!dm_rst_n) begin
            sbaddress0 <= '0;
        end else if (!dmactive) begin
            sbaddress0 <= '0;
        end else if (addr_wen) begin
            sbaddress0 <= dm_reg_data.raw;
        end else if (rsp_valid && !rsp_err && cfg_q.autoincrement) begin
            sbaddress0 <= sbaddress0 + addr_step;
        end
    end

    always_ff @(posedge dm_clk or negedge dm_rst_n) begin
        if (!dm_rst_n) begin
            sbdata0 <= '0;
        end else if (!dmactive) begin
            sbdata0 <= '0;
        end else if (data_wen) begin
            sbdata0 <= dm_reg_data.raw;
        end else if (rsp_valid && rsp_is_read && !rsp_err) begin
            sbdata0 <= load_data;
        end
    end

    a_one_request: assert property (@(posedge dm_clk) disable iff (!dm_rst_n)
        $onehot0({req_rd_addr, req_wr_data, req_rd_data}));

endmodule

// ==== hdl/dm_sb_pkg.sv ====
package dm_sb_pkg;

    // sbaccess encoding
    typedef enum logic [2:0] {
        SB_SIZE_BYTE  = 3'd0,
        SB_SIZE_HALF  = 3'd1,
        SB_SIZE_WORD  = 3'd2,
        SB_SIZE_DWORD = 3'd3
    } sb_size_e;

    // sberror encoding
    typedef enum logic [2:0] {
        SB_ERR_NONE  = 3'd0,
        SB_ERR_BUS   = 3'd2,
        SB_ERR_ALIGN = 3'd3,
        SB_ERR_SIZE  = 3'd4
    } sb_err_e;

    // sbcs as seen on a debug write
    typedef struct packed {
        logic [8:0]  rsvd_hi;        // version and reserved, read only
        logic        busyerror_clr;  // w1c
        logic        rsvd_busy;      // sbbusy, read only
        logic        readonaddr;
        sb_size_e    access;
        logic        autoincrement;
        logic        readondata;
        logic [2:0]  err_clr;        // w1c per bit
        logic [11:0] rsvd_lo;        // size and access caps, read only
    } sb_cs_fields_t;

    // one debug write word, taken as sbcs fields or as address/data
    typedef union packed {
        sb_cs_fields_t cs;
        logic [31:0]   raw;
    } sb_wword_u;

endpackage

// ==== hdl/dm_sb_macros.svh ====
`ifndef DM_SB_MACROS_SVH
`define DM_SB_MACROS_SVH

// debug register address width and map
`define DM_SB_ABITS         7
`define DM_SB_ADDR_SBCS     7'h38
`define DM_SB_ADDR_SBADDR0  7'h39
`define DM_SB_ADDR_SBDATA0  7'h3C

// system bus widths
`define DM_SB_ADDR_W        32
`define DM_SB_DATA_W        32
`define DM_SB_STRB_W        4

// sbcs version field, debug spec 1.0
`define DM_SB_VERSION       1

// axi response codes
`define DM_SB_RESP_OKAY     2'b00

`endif
